/* rtc_bus_cycle.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_bus_cycle #(
  parameter int PHASE_CYCLES = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           go,
  input  logic                           cyc_write,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] cyc_addr,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] cyc_data,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] ad_in,
  output logic                           cyc_fin,
  output logic                           bus_cs,
  output logic                           bus_as,
  output logic                           bus_wr,
  output logic                           bus_rd,
  output logic                           ad_oe,
  output logic [rtc_pkg::RTC_DATA_W-1:0] ad_out,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_rdata
);
  import rtc_pkg::*;

  // Counter must be at least one bit wide even for single-cycle phases
  localparam int CNT_W = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PHASE_CYCLES - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ADDR  = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_RECOV = 2'd3;

  logic [1:0]            state;
  logic [1:0]            state_nxt;
  logic [CNT_W-1:0]      cnt;
  logic                  last;
  logic                  write_q;
  logic [RTC_DATA_W-1:0] data_q;

  assign last    = (cnt == CNT_LAST);
  assign cyc_fin = (state == ST_RECOV) && last;

  ////////////////////
  // Phase sequencing
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (go) state_nxt = ST_ADDR;
      ST_ADDR:  if (last) state_nxt = ST_DATA;
      ST_DATA:  if (last) state_nxt = ST_RECOV;
      default:  if (last) state_nxt = ST_IDLE;
    endcase
  end

  // Strobes are registered from the next state so they line up with it
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      write_q <= 1'b0;
      bus_cs  <= 1'b0;
      bus_as  <= 1'b0;
      bus_wr  <= 1'b0;
      bus_rd  <= 1'b0;
      ad_oe   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_IDLE || last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      if (state == ST_IDLE && go) begin
        write_q <= cyc_write;
      end
      bus_cs <= (state_nxt == ST_ADDR) || (state_nxt == ST_DATA);
      bus_as <= (state_nxt == ST_ADDR);
      bus_wr <= (state_nxt == ST_DATA) && write_q;
      bus_rd <= (state_nxt == ST_DATA) && !write_q;
      ad_oe  <= (state_nxt == ST_ADDR) || ((state_nxt == ST_DATA) && write_q);
    end
  end

  ////////////////////
  // Address/data path
  ////////////////////

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && go) begin
      data_q <= cyc_data;
      ad_out <= cyc_addr;
    end else if (state == ST_ADDR && last) begin
      // Switch the shared bus over to the data byte
      ad_out <= data_q;
    end
    if (state == ST_DATA && last && !write_q) begin
      cyc_rdata <= ad_in;
    end
  end

endmodule

`default_nettype wire

/* rtc_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_ctrl_top #(
  parameter int PHASE_CYCLES = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           wr_start,
  input  logic                           rd_start,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] reg_addr,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] wr_data,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] ad_in,
  output logic                           busy,
  output logic                           wr_done,
  output logic                           rd_valid,
  output logic [rtc_pkg::RTC_DATA_W-1:0] rd_data,
  output logic                           bus_cs,
  output logic                           bus_as,
  output logic                           bus_wr,
  output logic                           bus_rd,
  output logic                           ad_oe,
  output logic [rtc_pkg::RTC_DATA_W-1:0] ad_out
);
  import rtc_pkg::*;

  // Arbiter to sequencers
  logic                  wseq_start;
  logic                  rseq_start;
  logic [RTC_DATA_W-1:0] seq_addr;
  logic [RTC_DATA_W-1:0] seq_data;

  // Sequencer bus requests
  logic                  wr_go;
  logic [RTC_DATA_W-1:0] wr_addr;
  logic [RTC_DATA_W-1:0] wr_dat;
  logic                  wr_write;
  logic                  rd_go;
  logic [RTC_DATA_W-1:0] rd_addr;

  // Muxed request and bus cycle response
  logic                  go;
  logic [RTC_DATA_W-1:0] cyc_addr;
  logic [RTC_DATA_W-1:0] cyc_data;
  logic                  cyc_write;
  logic                  cyc_fin;
  logic [RTC_DATA_W-1:0] cyc_rdata;

  rtc_host_arbiter rtc_host_arbiter_i (
    .clk        (clk),
    .reset      (reset),
    .wr_start   (wr_start),
    .rd_start   (rd_start),
    .reg_addr   (reg_addr),
    .wr_data    (wr_data),
    .wr_done_in (wr_done),
    .rd_done_in (rd_valid),
    .wr_go      (wr_go),
    .wr_addr    (wr_addr),
    .wr_dat     (wr_dat),
    .wr_write   (wr_write),
    .rd_go      (rd_go),
    .rd_addr    (rd_addr),
    .busy       (busy),
    .wseq_start (wseq_start),
    .rseq_start (rseq_start),
    .seq_addr   (seq_addr),
    .seq_data   (seq_data),
    .go         (go),
    .cyc_addr   (cyc_addr),
    .cyc_data   (cyc_data),
    .cyc_write  (cyc_write)
  );

  rtc_write_seq rtc_write_seq_i (
    .clk       (clk),
    .reset     (reset),
    .seq_start (wseq_start),
    .seq_addr  (seq_addr),
    .seq_data  (seq_data),
    .cyc_fin   (cyc_fin),
    .go        (wr_go),
    .cyc_addr  (wr_addr),
    .cyc_data  (wr_dat),
    .cyc_write (wr_write),
    .done      (wr_done)
  );

  rtc_read_seq rtc_read_seq_i (
    .clk       (clk),
    .reset     (reset),
    .seq_start (rseq_start),
    .seq_addr  (seq_addr),
    .cyc_fin   (cyc_fin),
    .cyc_rdata (cyc_rdata),
    .go        (rd_go),
    .cyc_addr  (rd_addr),
    .done      (rd_valid),
    .rd_data   (rd_data)
  );

  rtc_bus_cycle #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) rtc_bus_cycle_i (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .cyc_write (cyc_write),
    .cyc_addr  (cyc_addr),
    .cyc_data  (cyc_data),
    .ad_in     (ad_in),
    .cyc_fin   (cyc_fin),
    .bus_cs    (bus_cs),
    .bus_as    (bus_as),
    .bus_wr    (bus_wr),
    .bus_rd    (bus_rd),
    .ad_oe     (ad_oe),
    .ad_out    (ad_out),
    .cyc_rdata (cyc_rdata)
  );

endmodule

`default_nettype wire

/* rtc_host_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_host_arbiter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           wr_start,
  input  logic                           rd_start,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] reg_addr,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] wr_data,
  input  logic                           wr_done_in,
  input  logic                           rd_done_in,
  input  logic                           wr_go,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] wr_addr,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] wr_dat,
  input  logic                           wr_write,
  input  logic                           rd_go,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] rd_addr,
  output logic                           busy,
  output logic                           wseq_start,
  output logic                           rseq_start,
  output logic [rtc_pkg::RTC_DATA_W-1:0] seq_addr,
  output logic [rtc_pkg::RTC_DATA_W-1:0] seq_data,
  output logic                           go,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_addr,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_data,
  output logic                           cyc_write
);
  import rtc_pkg::*;

  logic accept;
  logic owner_wr;

  // Strobes while busy are dropped, write wins a tie
  assign accept = !busy && (wr_start || rd_start);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      owner_wr   <= 1'b0;
      wseq_start <= 1'b0;
      rseq_start <= 1'b0;
    end else begin
      wseq_start <= accept && wr_start;
      rseq_start <= accept && !wr_start;
      if (accept) begin
        busy     <= 1'b1;
        owner_wr <= wr_start;
      end else if (wr_done_in || rd_done_in) begin
        busy <= 1'b0;
      end
    end
  end

  // Operands held for the whole sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      seq_addr <= reg_addr;
      if (wr_start) begin
        seq_data <= wr_data;
      end
    end
  end

  ////////////////////
  // Bus request mux
  ////////////////////

  assign go        = busy && (owner_wr ? wr_go : rd_go);
  assign cyc_addr  = owner_wr ? wr_addr : rd_addr;
  assign cyc_data  = owner_wr ? wr_dat : {RTC_DATA_W{1'b0}};
  assign cyc_write = owner_wr && wr_write;

endmodule

`default_nettype wire

/* rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Address and data share one byte-wide bus
  localparam int RTC_DATA_W = 8;

  ////////////////////
  // Register map
  ////////////////////

  // Time registers, inclusive range
  localparam logic [RTC_DATA_W-1:0] TIME_ADDR_LO = 8'h41;
  localparam logic [RTC_DATA_W-1:0] TIME_ADDR_HI = 8'h43;

  // Transfer commands that make the chip commit a written value
  localparam logic [RTC_DATA_W-1:0] CMD_XFER_TIME = 8'hF2;
  localparam logic [RTC_DATA_W-1:0] CMD_XFER_RAM  = 8'hF0;

endpackage

`default_nettype wire

/* rtc_read_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_read_seq (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           seq_start,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] seq_addr,
  input  logic                           cyc_fin,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] cyc_rdata,
  output logic                           go,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_addr,
  output logic                           done,
  output logic [rtc_pkg::RTC_DATA_W-1:0] rd_data
);
  import rtc_pkg::*;

  // High while the single read cycle is in flight
  logic waiting;

  always_ff @(posedge clk) begin
    if (reset) begin
      waiting <= 1'b0;
      go      <= 1'b0;
      done    <= 1'b0;
    end else begin
      go   <= 1'b0;
      done <= 1'b0;
      if (!waiting && seq_start) begin
        waiting <= 1'b1;
        go      <= 1'b1;
      end else if (waiting && cyc_fin) begin
        waiting <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

  ////////////////////
  // Operand and result
  ////////////////////

  always_ff @(posedge clk) begin
    if (!waiting && seq_start) begin
      cyc_addr <= seq_addr;
    end
    // Byte is valid alongside cyc_fin, hold it for the host
    if (waiting && cyc_fin) begin
      rd_data <= cyc_rdata[RTC_DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* rtc_write_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_write_seq (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           seq_start,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] seq_addr,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] seq_data,
  input  logic                           cyc_fin,
  output logic                           go,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_addr,
  output logic [rtc_pkg::RTC_DATA_W-1:0] cyc_data,
  output logic                           cyc_write,
  output logic                           done
);
  import rtc_pkg::*;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_WRITE  = 2'd1;
  localparam logic [1:0] ST_XFER   = 2'd2;
  localparam logic [1:0] ST_FINISH = 2'd3;

  logic [1:0]            state;
  logic [RTC_DATA_W-1:0] addr_q;
  logic                  is_time;
  logic [RTC_DATA_W-1:0] xfer_cmd;

  // Time registers need their own commit command
  assign is_time  = (addr_q >= TIME_ADDR_LO) && (addr_q <= TIME_ADDR_HI);
  assign xfer_cmd = is_time ? CMD_XFER_TIME : CMD_XFER_RAM;

  // Both cycles of this sequence drive the bus
  assign cyc_write = 1'b1;
  assign done      = (state == ST_FINISH);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      go    <= 1'b0;
    end else begin
      go <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (seq_start) begin
            state <= ST_WRITE;
            go    <= 1'b1;
          end
        end
        ST_WRITE: begin
          // Data cycle over, launch the transfer command
          if (cyc_fin) begin
            state <= ST_XFER;
            go    <= 1'b1;
          end
        end
        ST_XFER: begin
          if (cyc_fin) begin
            state <= ST_FINISH;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Operands for the data cycle, then the command cycle
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && seq_start) begin
      addr_q   <= seq_addr;
      cyc_addr <= seq_addr;
      cyc_data <= seq_data;
    end else if (state == ST_WRITE && cyc_fin) begin
      cyc_addr <= xfer_cmd;
      cyc_data <= xfer_cmd;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rtc_ctrl -f vlog.f -o tb_rtc_ctrl \
  && ./obj_dir/tb_rtc_ctrl | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* tb_rtc_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rtc_chip_model (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           bus_cs,
  input  logic                           bus_as,
  input  logic                           bus_wr,
  input  logic                           bus_rd,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] ad_out,
  input  logic [rtc_pkg::RTC_DATA_W-1:0] peek_addr,
  output logic [rtc_pkg::RTC_DATA_W-1:0] ad_in,
  output logic [rtc_pkg::RTC_DATA_W-1:0] peek_data,
  output logic [rtc_pkg::RTC_DATA_W-1:0] xfer_count,
  output logic [rtc_pkg::RTC_DATA_W-1:0] last_cmd
);
  import rtc_pkg::*;

  logic [RTC_DATA_W-1:0] regs [0:(1 << RTC_DATA_W)-1];
  logic [RTC_DATA_W-1:0] addr_q;
  logic                  wr_q;
  logic                  is_cmd;

  // Command codes arrive in the address phase and are never stored
  assign is_cmd    = (addr_q == CMD_XFER_TIME) || (addr_q == CMD_XFER_RAM);
  assign ad_in     = bus_rd ? regs[addr_q] : '0;
  assign peek_data = regs[peek_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q     <= '0;
      wr_q       <= 1'b0;
      xfer_count <= '0;
      last_cmd   <= '0;
      // Preload depends on every address bit
      for (int i = 0; i < (1 << RTC_DATA_W); i++) begin
        regs[i] <= RTC_DATA_W'(i) ^ 8'hA5;
      end
    end else begin
      wr_q <= bus_wr;
      if (bus_cs && bus_as) begin
        addr_q <= ad_out;
      end
      if (bus_cs && bus_wr) begin
        if (is_cmd) begin
          // One count per data phase
          if (!wr_q) begin
            xfer_count <= xfer_count + 8'd1;
            last_cmd   <= ad_out;
          end
        end else begin
          regs[addr_q] <= ad_out;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_rtc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rtc_ctrl;
  import rtc_pkg::*;

  localparam int PHASE_CYCLES = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int NUM_RAND     = 16;
  // Host operations issued, with room for the idle stretches
  localparam int NUM_OPS      = 14 + 2 * NUM_RAND;
  localparam int WATCHDOG_NS  = 2 * NUM_OPS * 6 * PHASE_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;
  localparam int DONE_LIMIT   = 8 * PHASE_CYCLES + 8;

  logic                  clk;
  logic                  reset;
  logic                  wr_start;
  logic                  rd_start;
  logic [RTC_DATA_W-1:0] reg_addr;
  logic [RTC_DATA_W-1:0] wr_data;
  logic [RTC_DATA_W-1:0] ad_in;
  logic                  busy;
  logic                  wr_done;
  logic                  rd_valid;
  logic [RTC_DATA_W-1:0] rd_data;
  logic                  bus_cs;
  logic                  bus_as;
  logic                  bus_wr;
  logic                  bus_rd;
  logic                  ad_oe;
  logic [RTC_DATA_W-1:0] ad_out;
  logic [RTC_DATA_W-1:0] peek_addr;
  logic [RTC_DATA_W-1:0] peek_data;
  logic [RTC_DATA_W-1:0] xfer_count;
  logic [RTC_DATA_W-1:0] last_cmd;

  integer seed;
  int     errors;
  int     checks;
  // Expected register contents of the chip
  logic [RTC_DATA_W-1:0] shadow [0:(1 << RTC_DATA_W)-1];

  rtc_ctrl_top #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) rtc_ctrl_top_i (
    .clk      (clk),
    .reset    (reset),
    .wr_start (wr_start),
    .rd_start (rd_start),
    .reg_addr (reg_addr),
    .wr_data  (wr_data),
    .ad_in    (ad_in),
    .busy     (busy),
    .wr_done  (wr_done),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .bus_cs   (bus_cs),
    .bus_as   (bus_as),
    .bus_wr   (bus_wr),
    .bus_rd   (bus_rd),
    .ad_oe    (ad_oe),
    .ad_out   (ad_out)
  );

  tb_rtc_chip_model chip_model_i (
    .clk        (clk),
    .reset      (reset),
    .bus_cs     (bus_cs),
    .bus_as     (bus_as),
    .bus_wr     (bus_wr),
    .bus_rd     (bus_rd),
    .ad_out     (ad_out),
    .peek_addr  (peek_addr),
    .ad_in      (ad_in),
    .peek_data  (peek_data),
    .xfer_count (xfer_count),
    .last_cmd   (last_cmd)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Compare helpers
  ////////////////////

  task automatic check_byte(input string what, input logic [RTC_DATA_W-1:0] got,
                            input logic [RTC_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic logic [RTC_DATA_W-1:0] expected_cmd(input logic [RTC_DATA_W-1:0] addr);
    if (addr >= TIME_ADDR_LO && addr <= TIME_ADDR_HI) begin
      return CMD_XFER_TIME;
    end else begin
      return CMD_XFER_RAM;
    end
  endfunction

  task automatic peek_check(input string what, input logic [RTC_DATA_W-1:0] addr,
                            input logic [RTC_DATA_W-1:0] exp);
    peek_addr = addr;
    #1;
    check_byte(what, peek_data, exp);
  endtask

  ////////////////////
  // Host driving
  ////////////////////

  task automatic issue_strobe(input logic wr, input logic rd,
                              input logic [RTC_DATA_W-1:0] addr,
                              input logic [RTC_DATA_W-1:0] data);
    @(negedge clk);
    wr_start = wr;
    rd_start = rd;
    reg_addr = addr;
    wr_data  = data;
    @(negedge clk);
    wr_start = 1'b0;
    rd_start = 1'b0;
  endtask

  // Busy must hold until the wanted done strobe, the other strobe stays low
  task automatic wait_for_done(input logic want_wr);
    int   cycles;
    int   oe_cycles;
    logic seen;
    cycles    = 0;
    oe_cycles = 0;
    seen      = 1'b0;
    while (!seen && cycles < DONE_LIMIT) begin
      check_flag("busy while running", busy, 1'b1);
      if (ad_oe === 1'b1) begin
        oe_cycles++;
      end
      if (want_wr) begin
        check_flag("rd_valid during write", rd_valid, 1'b0);
        seen = wr_done;
      end else begin
        check_flag("wr_done during read", wr_done, 1'b0);
        seen = rd_valid;
      end
      if (!seen) begin
        @(negedge clk);
        cycles++;
      end
    end
    if (!seen) begin
      errors++;
      $display("No done strobe within %0d cycles, at %0t ns", DONE_LIMIT, $time);
    end else begin
      // Driven in both phases of each write cycle and only the address phase of a read
      check_count("ad_oe cycles", oe_cycles, want_wr ? 4 * PHASE_CYCLES : PHASE_CYCLES);
    end
  endtask

  task automatic check_busy_drop();
    @(negedge clk);
    check_flag("busy after done", busy, 1'b0);
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("busy while idle", busy, 1'b0);
      check_flag("wr_done while idle", wr_done, 1'b0);
      check_flag("rd_valid while idle", rd_valid, 1'b0);
    end
  endtask

  task automatic do_write(input logic [RTC_DATA_W-1:0] addr,
                          input logic [RTC_DATA_W-1:0] data, input logic also_read);
    logic [RTC_DATA_W-1:0] count_before;
    count_before = xfer_count;
    issue_strobe(1'b1, also_read, addr, data);
    wait_for_done(1'b1);
    check_busy_drop();
    shadow[addr] = data;
    check_byte("transfer count", xfer_count, count_before + 8'd1);
    check_byte("transfer command", last_cmd, expected_cmd(addr));
    peek_check("stored byte", addr, data);
  endtask

  task automatic do_read(input logic [RTC_DATA_W-1:0] addr);
    issue_strobe(1'b0, 1'b1, addr, 8'h00);
    wait_for_done(1'b0);
    check_byte("read data", rd_data, shadow[addr]);
    check_busy_drop();
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic check_reset_state();
    check_flag("busy in reset", busy, 1'b0);
    check_flag("wr_done in reset", wr_done, 1'b0);
    check_flag("rd_valid in reset", rd_valid, 1'b0);
    check_flag("bus_cs in reset", bus_cs, 1'b0);
    check_flag("bus_as in reset", bus_as, 1'b0);
    check_flag("bus_wr in reset", bus_wr, 1'b0);
    check_flag("bus_rd in reset", bus_rd, 1'b0);
    check_flag("ad_oe in reset", ad_oe, 1'b0);
  endtask

  task automatic test_ram_write();
    do_write(8'h10, 8'h3C, 1'b0);
  endtask

  task automatic test_time_writes();
    do_write(8'h41, 8'h12, 1'b0);
    do_write(8'h42, 8'h34, 1'b0);
    do_write(8'h43, 8'h56, 1'b0);
    // Just past the time range
    do_write(8'h44, 8'h78, 1'b0);
  endtask

  task automatic test_reads();
    do_read(8'h10);
    do_read(8'h42);
    // Never written, so this is the preload
    do_read(8'h30);
  endtask

  task automatic test_busy_drop();
    logic [RTC_DATA_W-1:0] count_before;
    count_before = xfer_count;
    issue_strobe(1'b1, 1'b0, 8'h11, 8'h5C);
    check_flag("busy after accept", busy, 1'b1);
    // Both strobes land mid-sequence and must be dropped
    issue_strobe(1'b1, 1'b1, 8'h20, 8'hEE);
    wait_for_done(1'b1);
    check_busy_drop();
    shadow[8'h11] = 8'h5C;
    check_idle(8 * PHASE_CYCLES);
    check_byte("transfer count", xfer_count, count_before + 8'd1);
    peek_check("written byte", 8'h11, 8'h5C);
    peek_check("untouched byte", 8'h20, shadow[8'h20]);
  endtask

  task automatic test_simultaneous();
    do_write(8'h12, 8'hA7, 1'b1);
    check_idle(8 * PHASE_CYCLES);
  endtask

  task automatic test_random();
    logic [RTC_DATA_W-1:0] addrs [NUM_RAND];
    logic [RTC_DATA_W-1:0] data;
    for (int i = 0; i < NUM_RAND; i++) begin
      // Stay clear of the command codes
      addrs[i] = RTC_DATA_W'($random(seed)) & 8'h7F;
      data     = RTC_DATA_W'($random(seed));
      do_write(addrs[i], data, 1'b0);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      do_read(addrs[i]);
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    wr_start  = 1'b0;
    rd_start  = 1'b0;
    reg_addr  = '0;
    wr_data   = '0;
    peek_addr = '0;
    seed      = 23;
    errors    = 0;
    checks    = 0;
    for (int i = 0; i < (1 << RTC_DATA_W); i++) begin
      shadow[i] = RTC_DATA_W'(i) ^ 8'hA5;
    end
    repeat (8) @(negedge clk);
    check_reset_state();
    reset = 1'b0;
    test_ram_write();
    test_time_writes();
    test_reads();
    test_busy_drop();
    test_simultaneous();
    test_random();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtc_pkg.sv
rtc_bus_cycle.sv
rtc_write_seq.sv
rtc_read_seq.sv
rtc_host_arbiter.sv
rtc_ctrl_top.sv
tb_rtc_chip_model.sv
tb_rtc_ctrl.sv
